/* include/spi_read_cfg.svh */
`ifndef SPI_READ_CFG_SVH
`define SPI_READ_CFG_SVH

// clk cycles per sck phase.
`define SCK_HALF 1

// 64-bit words in the flash array, power of two.
`define FLASH_WORDS 1024

// word index width.
`define FLASH_IDX_W ($clog2(`FLASH_WORDS))

// opcode plus 24-bit address.
`define HDR_BITS 32

// one flash word per transfer.
`define DATA_BITS 64

`endif

/* rtl/spi_read_pkg.sv */
`default_nettype none

`include "spi_read_cfg.svh"

package spi_read_pkg;

  // plain read, the only opcode the device answers.
  localparam logic [7:0] READ_OP = 8'h03;

  // host request, also the header word sent msb first.
  typedef struct packed {
    logic [7:0]  opcode;
    logic [23:0] addr;
  } host_req_t;

  // master side of the spi bus.
  typedef struct packed {
    logic sck;
    logic cs_n;
    logic mosi;
  } spi_pins_t;

  // controller to serdes.
  typedef struct packed {
    logic load;   // start of a phase.
    logic run;    // frame in progress.
    logic phase;  // 0 header, 1 data.
  } serdes_ctl_t;

  // one flash word, byte 0 holds the lowest address.
  typedef union packed {
    logic [`DATA_BITS-1:0]        dword;
    logic [`DATA_BITS/8-1:0][7:0] bytes;
  } flash_word_u;

endpackage

`default_nettype wire

/* rtl/spi_read_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_read_ctrl (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        req,
  input  wire                        done,
  output logic                       ack,
  output logic                       cs_n,
  output spi_read_pkg::serdes_ctl_t  ctl
);

  typedef enum logic [2:0] {
    s_idle,
    s_header,
    s_data,
    s_release,
    s_complete
  } ctrl_state_t;

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      s_idle: begin
        if (req) begin
          state_d = s_header;
        end
      end
      s_header: begin
        if (done) begin
          state_d = s_data;
        end
      end
      s_data: begin
        if (done) begin
          state_d = s_release;
        end
      end
      s_release: begin
        state_d = s_complete;  // cs_n high one cycle before ack.
      end
      s_complete: begin
        if (!req) begin
          state_d = s_idle;  // host closed the handshake.
        end
      end
      default: begin
        state_d = s_idle;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q <= s_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // chip select spans both phases.
  assign cs_n = !(state_q == s_header || state_q == s_data);
  // held while the host keeps req high.
  assign ack  = (state_q == s_complete);

  // load lands on the same edge the phase starts, so the phases run back to back.
  always_comb begin
    ctl.load  = (state_q == s_idle && req) || (state_q == s_header && done);
    ctl.run   = (state_q == s_header) || (state_q == s_data);
    ctl.phase = (state_q == s_data) || (state_q == s_header && done);
  end

endmodule

`default_nettype wire

/* rtl/spi_serdes.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spi_read_cfg.svh"

module spi_serdes (
  input  wire                           clk,
  input  wire                           reset,
  input  wire spi_read_pkg::serdes_ctl_t ctl,
  input  wire                           cs_n,
  input  wire spi_read_pkg::host_req_t  req_data,
  input  wire                           miso,
  output spi_read_pkg::spi_pins_t       pins,
  output logic                          done,
  output spi_read_pkg::flash_word_u     rdata
);

  import spi_read_pkg::*;

  localparam int DIV_W = $clog2(`SCK_HALF) + 1;
  localparam int POS_W = $clog2(`DATA_BITS);

  logic             sck_r;
  logic             sck_d;
  logic [DIV_W-1:0] div_q;
  logic [POS_W-1:0] bit_q;
  logic [POS_W-1:0] last_bit;
  logic             busy_q;
  logic             tick;
  logic             rx_en;
  host_req_t        tx_q;

  assign tick     = (div_q == DIV_W'(`SCK_HALF - 1));
  assign last_bit = ctl.phase ? POS_W'(`DATA_BITS - 1) : POS_W'(`HDR_BITS - 1);
  // one clk after our own rise, same as the device sees it.
  assign rx_en    = ctl.run & ctl.phase & sck_r & ~sck_d;

  assign pins = '{sck: sck_r, cs_n: cs_n, mosi: tx_q[`HDR_BITS-1]};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sck_r  <= 1'b0;
      sck_d  <= 1'b0;
      div_q  <= '0;
      bit_q  <= '0;
      busy_q <= 1'b0;
      done   <= 1'b0;
      tx_q   <= '0;
    end else begin
      sck_d <= sck_r;
      done  <= 1'b0;
      if (ctl.load) begin
        busy_q <= 1'b1;
        bit_q  <= '0;
        div_q  <= '0;
        sck_r  <= 1'b0;
        if (!ctl.phase) begin
          tx_q <= req_data;  // first bit on mosi right away.
        end
      end else if (busy_q && ctl.run) begin
        if (tick) begin
          div_q <= '0;
          sck_r <= ~sck_r;
          if (sck_r) begin
            // falling edge, next bit out.
            tx_q  <= {tx_q[`HDR_BITS-2:0], 1'b0};
            bit_q <= bit_q + POS_W'(1);
            if (bit_q == last_bit) begin
              busy_q <= 1'b0;
              done   <= 1'b1;
            end
          end
        end else begin
          div_q <= div_q + DIV_W'(1);
        end
      end
    end
  end

  // byte lane by bit count, msb first within the byte.
  always_ff @(posedge clk) begin
    if (rx_en) begin
      rdata.bytes[bit_q[POS_W-1:3]][3'd7 - bit_q[2:0]] <= miso;
    end
  end

endmodule

`default_nettype wire

/* rtl/flash_cmd_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spi_read_cfg.svh"

module flash_cmd_decoder (
  input  wire                           clk,
  input  wire                           reset,
  input  wire spi_read_pkg::spi_pins_t  pins,
  input  wire spi_read_pkg::flash_word_u rd_word,
  output logic                          miso,
  output logic                          rd_en,
  output logic [`FLASH_IDX_W-1:0]       rd_index
);

  import spi_read_pkg::*;

  typedef enum logic [1:0] {
    s_cmd,
    s_addr,
    s_data,
    s_ignore
  } dev_state_t;

  dev_state_t              state_q;
  logic                    sck_q;
  logic                    rise;
  logic                    fall;
  logic [5:0]              cnt_q;
  logic [6:0]              op_q;
  logic [`FLASH_IDX_W-1:0] addr_q;
  flash_word_u             word_q;
  flash_word_u             out_word;
  logic                    out_bit;
  logic                    miso_q;

  assign rise = ~pins.cs_n & pins.sck & ~sck_q;
  assign fall = ~pins.cs_n & ~pins.sck & sck_q;

  // strobe on the last header bit, the index is complete by then.
  assign rd_en    = rise && (state_q == s_addr) && (cnt_q == 6'(`HDR_BITS - 1));
  assign rd_index = addr_q;

  // first data bit goes out before word_q holds the word.
  assign out_word = (cnt_q == 6'd0) ? rd_word : word_q;
  assign out_bit  = out_word.bytes[cnt_q[5:3]][3'd7 - cnt_q[2:0]];

  // released line reads high.
  assign miso = miso_q | pins.cs_n;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q <= s_cmd;
      sck_q   <= 1'b0;
      cnt_q   <= '0;
      miso_q  <= 1'b1;
    end else begin
      sck_q <= pins.sck;
      if (pins.cs_n) begin
        state_q <= s_cmd;
        cnt_q   <= '0;
        miso_q  <= 1'b1;
      end else begin
        case (state_q)
          s_cmd: begin
            if (rise) begin
              cnt_q <= cnt_q + 6'd1;
              if (cnt_q == 6'd7) begin
                state_q <= ({op_q, pins.mosi} == READ_OP) ? s_addr : s_ignore;
              end
            end
          end
          s_addr: begin
            if (rise) begin
              if (cnt_q == 6'(`HDR_BITS - 1)) begin
                state_q <= s_data;
                cnt_q   <= '0;
              end else begin
                cnt_q <= cnt_q + 6'd1;
              end
            end
          end
          s_data: begin
            if (fall) begin
              miso_q <= out_bit;
              cnt_q  <= cnt_q + 6'd1;
            end
          end
          default: begin
            state_q <= s_ignore;  // unsupported opcode, wait for cs_n.
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rise && state_q == s_cmd) begin
      op_q <= {op_q[5:0], pins.mosi};
    end
    // stop at address bit 3, keeps the index modulo the array size.
    if (rise && state_q == s_addr && cnt_q <= 6'(`HDR_BITS - 4)) begin
      addr_q <= {addr_q[`FLASH_IDX_W-2:0], pins.mosi};
    end
    if (fall && state_q == s_data && cnt_q == 6'd0) begin
      word_q <= rd_word;
    end
  end

endmodule

`default_nettype wire

/* rtl/flash_array.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spi_read_cfg.svh"

module flash_array (
  input  wire                           clk,
  input  wire                           rd_en,
  input  wire [`FLASH_IDX_W-1:0]        rd_index,
  output spi_read_pkg::flash_word_u     rd_word
);

  import spi_read_pkg::*;

  flash_word_u mem [`FLASH_WORDS];

  // content of byte address a.
  function automatic logic [7:0] byte_at(input logic [12:0] a);
    return (a[7:0] ^ 8'hA5) + 8'(a[12:8]);
  endfunction

  initial begin
    for (int i = 0; i < `FLASH_WORDS; i++) begin
      for (int j = 0; j < `DATA_BITS / 8; j++) begin
        mem[i].bytes[j] = byte_at(13'(i * 8 + j));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_word <= mem[rd_index];
    end
  end

endmodule

`default_nettype wire

/* rtl/spi_read_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spi_read_cfg.svh"

module spi_read_top (
  input  wire                           clk,
  input  wire                           reset,
  input  wire                           req,
  input  wire spi_read_pkg::host_req_t  req_data,
  output logic                          ack,
  output spi_read_pkg::flash_word_u     rdata,
  output spi_read_pkg::spi_pins_t       pins,
  output logic                          miso
);

  import spi_read_pkg::*;

  logic                    done;
  logic                    cs_n;
  serdes_ctl_t             ctl;
  logic                    rd_en;
  logic [`FLASH_IDX_W-1:0] rd_index;
  flash_word_u             rd_word;

  spi_read_ctrl ctrl_i (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .done  (done),
    .ack   (ack),
    .cs_n  (cs_n),
    .ctl   (ctl)
  );

  spi_serdes serdes_i (
    .clk      (clk),
    .reset    (reset),
    .ctl      (ctl),
    .cs_n     (cs_n),
    .req_data (req_data),
    .miso     (miso),
    .pins     (pins),
    .done     (done),
    .rdata    (rdata)
  );

  // device side of the bus.
  flash_cmd_decoder flash_i (
    .clk      (clk),
    .reset    (reset),
    .pins     (pins),
    .rd_word  (rd_word),
    .miso     (miso),
    .rd_en    (rd_en),
    .rd_index (rd_index)
  );

  flash_array array_i (
    .clk      (clk),
    .rd_en    (rd_en),
    .rd_index (rd_index),
    .rd_word  (rd_word)
  );

endmodule

`default_nettype wire

/* dv/spi_read_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_read_sva (
  input wire                          clk,
  input wire                          reset,
  input wire                          req,
  input wire                          ack,
  input wire spi_read_pkg::spi_pins_t pins
);

  // ack only answers a pending request.
  ack_rise_with_req: assert property (
    @(posedge clk) disable iff (reset)
    $rose(ack) |-> $past(req)
  ) else $error("ack rose while req was low");

  // ack drops only once the host has let go of req.
  ack_fall_after_req: assert property (
    @(posedge clk) disable iff (reset)
    $fell(ack) |-> !$past(req)
  ) else $error("ack fell while req was still high");

  // bus quiet outside a frame.
  bus_idle_when_deselected: assert property (
    @(posedge clk) disable iff (reset)
    pins.cs_n |-> (!pins.sck && !pins.mosi)
  ) else $error("sck or mosi active while cs_n was high");

  ack_only_deselected: assert property (
    @(posedge clk) disable iff (reset)
    ack |-> pins.cs_n
  ) else $error("ack high while cs_n was low");

endmodule

bind spi_read_top spi_read_sva sva_i (
  .clk   (clk),
  .reset (reset),
  .req   (req),
  .ack   (ack),
  .pins  (pins)
);

`default_nettype wire

/* dv/spi_read_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spi_read_cfg.svh"

module spi_read_tb;

  import spi_read_pkg::*;

  localparam int CLK_HALF  = 4;
  localparam int MAX_LAT   = 200;
  localparam int HOLD_CYC  = 20;
  localparam int NUM_READS = 40;
  localparam int WATCHDOG  = NUM_READS * (MAX_LAT + 10) + HOLD_CYC + 200;

  logic        clk;
  logic        reset;
  logic        req;
  host_req_t   req_data;
  logic        ack;
  flash_word_u rdata;
  spi_pins_t   pins;
  logic        miso;

  int          checks;
  int          errors;
  int          tests;
  logic [31:0] lcg_state;

  spi_read_top dut_i (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rdata    (rdata),
    .pins     (pins),
    .miso     (miso)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("watchdog expired after %0d cycles, a read never completed", WATCHDOG);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // drive and sample 1 ns after the edge.
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // word the host should see for a request.
  function automatic logic [63:0] expected_word(input host_req_t r);
    logic [63:0] w;
    logic [23:0] idx;
    logic [23:0] a;
    if (r.opcode != 8'h03) begin
      return {64{1'b1}};  // line released, all ones.
    end
    idx = {3'b000, r.addr[23:3]} % 24'(`FLASH_WORDS);
    for (int j = 0; j < 8; j++) begin
      a = idx * 24'd8 + 24'(j);
      w[j*8 +: 8] = (a[7:0] ^ 8'hA5) + {3'b000, a[12:8]};
    end
    return w;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      $display("ERROR: %s", what);
      errors++;
    end
  endtask

  // one four-phase read, req held for hold cycles after ack.
  task automatic do_read(input logic [7:0] op, input logic [23:0] addr, input int hold);
    host_req_t   r;
    logic [63:0] held;
    int          lat;
    r.opcode = op;
    r.addr   = addr;
    req_data = r;
    req      = 1'b1;
    lat      = 0;
    step();
    while (!ack && lat < MAX_LAT + 10) begin
      step();
      lat++;
    end
    check_true(ack && lat <= MAX_LAT,
               $sformatf("no ack within %0d cycles for address %h", MAX_LAT, addr));
    check_value("rdata", rdata.dword, expected_word(r));
    check_true(pins.cs_n, "cs_n low when ack rose");
    held = rdata.dword;
    repeat (hold) begin
      step();
      check_true(ack, "ack dropped while req was held high");
      check_value("rdata (held)", rdata.dword, held);
      check_true(pins.cs_n && !pins.sck, "bus activity while ack was held");
    end
    req = 1'b0;
    lat = 0;
    while (ack && lat < 5) begin
      step();
      lat++;
    end
    check_true(!ack, "ack did not fall after req dropped");
  endtask

  task automatic report_test(input string name, input int err_start);
    tests++;
    $display("test %-12s %s, %0d errors", name,
             (errors == err_start) ? "done" : "had errors", errors - err_start);
  endtask

  task automatic test_reset();
    repeat (4) begin
      check_true(!ack, "ack high after reset");
      check_true(pins.cs_n, "cs_n low after reset");
      check_true(!pins.sck && !pins.mosi, "sck or mosi active after reset");
      check_true(miso, "miso not released after reset");
      step();
    end
  endtask

  task automatic test_unaligned();
    for (int k = 1; k < 8; k++) begin
      do_read(8'h03, 24'(k * 24'h111), 0);  // low bits equal k.
    end
    do_read(8'h03, 24'h002010, 0);
    do_read(8'h03, 24'hFFFFFF, 0);
  endtask

  task automatic test_random();
    repeat (24) begin
      lcg_state = lcg_next(lcg_state);
      do_read(8'h03, lcg_state[31:8], 0);
    end
  endtask

  initial begin
    int mark;
    reset     = 1'b1;
    req       = 1'b0;
    req_data  = '0;
    checks    = 0;
    errors    = 0;
    tests     = 0;
    lcg_state = 32'h4355_c9f2;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    mark = errors;
    test_reset();
    report_test("reset", mark);

    mark = errors;
    do_read(8'h03, 24'h000000, 0);
    do_read(8'h03, 24'h000008, 0);
    do_read(8'h03, 24'h001FF8, 0);
    report_test("aligned", mark);

    mark = errors;
    test_unaligned();
    report_test("unaligned", mark);

    mark = errors;
    do_read(8'h0B, 24'h000100, 0);
    do_read(8'h9F, 24'h000000, 0);
    report_test("opcodes", mark);

    mark = errors;
    do_read(8'h03, 24'h000A48, HOLD_CYC);
    do_read(8'h03, 24'h000A50, 0);
    report_test("backpressure", mark);

    mark = errors;
    test_random();
    report_test("random", mark);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
rtl/spi_read_pkg.sv
rtl/spi_read_ctrl.sv
rtl/spi_serdes.sv
rtl/flash_cmd_decoder.sv
rtl/flash_array.sv
rtl/spi_read_top.sv
dv/spi_read_sva.sv
dv/spi_read_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= spi_read_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

FAIL_MSG  := TESTBENCH FAILED
PASS_MSG  := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
